// ==== verilog.f ====
common/ksPkg.sv
pager/pageTable.sv
design/memCycleDecode.sv
design/intervalTimer.sv
design/pageFailDispatch.sv
design/pfUnit.sv
test/pfUnit_chk.sv
test/pfUnit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the pfUnit testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module pfUnit_tb -f verilog.f -o pfUnitSim \
   || { echo "Verilator build failed"; exit 1; }

./obj_dir/pfUnitSim > sim.log 2>&1
cat sim.log

grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "Simulation ended without passing"; exit 1; }
echo "Simulation finished cleanly"

// ==== test/pfUnit_tb.sv ====
/*
 * Directed testbench for the page-fail unit
 * Clock, reset, page table model, directed tests, watchdog
 */

`timescale 1ns/1ns
`default_nettype none

module pfUnit_tb
   import ksPkg::*;
();

   // Cycle budgets of the tests
   localparam int budgetHandshake = 120;
   localparam int budgetFaults    = 140;
   localparam int budgetIntr      = 60;
   localparam int budgetTimer     = 220;
   localparam int budgetStall     = 80;
   localparam int watchdogCycles  = budgetHandshake + budgetFaults + budgetIntr +
                                    budgetTimer + budgetStall + timerPeriod * 4;
   localparam int stallCycles     = 6;

   logic                clk;
   logic                rst;
   logic                clken;
   uOpT                 microOp;
   logic                vmaUser;
   logic                vmaPhys;
   logic                vmaAcRef;
   logic [pageBits-1:0] vmaPage;
   logic                pageEnable;
   logic                piIntr;
   logic                nxmIntr;
   logic                ptWrReq;
   logic [pageBits-1:0] ptWrPage;
   logic                ptWrValid;
   logic                ptWrUser;
   logic                ptWrWriteable;
   logic                ptWrAck;
   logic                pageFail;
   dispT                dispPf;

   // Reference copy of the page flags and of the dispatch register
   logic modelValid [pageCount];
   logic modelUser [pageCount];
   logic modelWr [pageCount];
   dispT expDisp;

   pfUnit i_pfUnit (
      .clk           (clk),
      .rst           (rst),
      .clken         (clken),
      .microOp       (microOp),
      .vmaUser       (vmaUser),
      .vmaPhys       (vmaPhys),
      .vmaAcRef      (vmaAcRef),
      .vmaPage       (vmaPage),
      .pageEnable    (pageEnable),
      .piIntr        (piIntr),
      .nxmIntr       (nxmIntr),
      .ptWrReq       (ptWrReq),
      .ptWrPage      (ptWrPage),
      .ptWrValid     (ptWrValid),
      .ptWrUser      (ptWrUser),
      .ptWrWriteable (ptWrWriteable),
      .ptWrAck       (ptWrAck),
      .pageFail      (pageFail),
      .dispPf        (dispPf)
   );

   always #20 clk = ~clk;

   //////////////////////////////////////////////////
   // Reporting
   //////////////////////////////////////////////////

   task automatic stopRun(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic checkVal(input string name, input logic [31:0] got,
                           input logic [31:0] want);
      if (got !== want)
         stopRun($sformatf("Fail at %0t ns: %s = %0h, expected %0h",
                           $time, name, got, want));
   endtask

   //////////////////////////////////////////////////
   // Model and drivers
   //////////////////////////////////////////////////

   // Cause priority for the address and levels now driven
   function automatic dispT predictDisp(input logic intrWin, input logic pfWin,
                                        input logic wrT, input logic timer);
      logic paged;
      logic inv;
      logic mis;
      logic wrFail;
      paged  = pageEnable && !vmaPhys && !vmaAcRef;
      inv    = paged && !modelValid[vmaPage];
      mis    = paged && (vmaUser != modelUser[vmaPage]);
      wrFail = paged && wrT && !modelWr[vmaPage];
      if (intrWin && nxmIntr)
         return dispNxm;
      if (intrWin && piIntr)
         return dispIntr;
      if (intrWin && timer && inv)
         return dispTimPagFail;
      if (intrWin && timer)
         return dispIntr;
      if (pfWin && inv)
         return dispInvalid;
      if (pfWin && mis)
         return dispMismatch;
      if (pfWin && wrFail)
         return dispWriteFail;
      return dispNone;
   endfunction

   task automatic resetDut();
      @(posedge clk);
      rst <= 1'b1;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      expDisp = dispNone;
      for (int p = 0; p < pageCount; p++)
         modelValid[p] = 1'b0;
   endtask

   // First sample comes before the edge that sees the new req
   task automatic waitAck(input logic level);
      int n;
      n = 0;
      do
      begin
         @(negedge clk);
         n++;
      end
      while (ptWrAck !== level && n < 8);
      if (ptWrAck !== level)
         stopRun("ptWrAck never followed ptWrReq");
      else
         checkVal("ptWrAck delay", 32'(n), 32'd2);
   endtask

   // Full four-phase write of one entry
   task automatic writePage(input logic [pageBits-1:0] page, input logic valid,
                            input logic user, input logic writeable);
      @(posedge clk);
      ptWrReq       <= 1'b1;
      ptWrPage      <= page;
      ptWrValid     <= valid;
      ptWrUser      <= user;
      ptWrWriteable <= writeable;
      waitAck(1'b1);
      @(posedge clk);
      ptWrReq <= 1'b0;
      waitAck(1'b0);
      modelValid[page] = valid;
      modelUser[page]  = user;
      modelWr[page]    = writeable;
   endtask

   task automatic setAddr(input logic [pageBits-1:0] page, input logic user,
                          input logic phys, input logic acRef, input logic pe);
      @(posedge clk);
      vmaPage    <= page;
      vmaUser    <= user;
      vmaPhys    <= phys;
      vmaAcRef   <= acRef;
      pageEnable <= pe;
   endtask

   task automatic setIntr(input logic nxm, input logic pi);
      @(posedge clk);
      nxmIntr <= nxm;
      piIntr  <= pi;
   endtask

   // One opcode with pageFail checked in its window and dispPf a cycle later
   task automatic runOp(input uOpT op, input logic timer);
      dispT want;
      logic isMem;
      @(posedge clk);
      microOp <= op;
      // Address and levels settled by the previous edge
      isMem = (op == opRead) || (op == opWrite) || (op == opWrTest);
      want  = predictDisp(op == opFetch, isMem, op == opWrTest, timer);
      @(posedge clk);
      microOp <= opNop;
      @(negedge clk);
      checkVal("pageFail", 32'(pageFail), 32'(want != dispNone));
      if (want != dispNone)
         expDisp = want;
      else if (op == opMemClr)
         expDisp = dispNone;
      @(negedge clk);
      checkVal("dispPf", 32'(dispPf), 32'(expDisp));
   endtask

   // Enabled edges until the next timer interrupt
   task automatic timerInterval();
      int n;
      n = 0;
      do
      begin
         @(posedge clk);
         n++;
         @(negedge clk);
      end
      while (!i_pfUnit.i_intervalTimer.timerIntr && n < 2 * timerPeriod);
      checkVal("timer interval", 32'(n), 32'(timerPeriod));
   endtask

   //////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////

   task automatic handshakeAndInvalid();
      logic [2:0] flags;
      for (int p = 0; p < pageCount; p++)
      begin
         flags = 3'($urandom);
         writePage(pageBits'(p), flags[0], flags[1], flags[2]);
      end
      // Page 3 forced invalid
      writePage(pageBits'(3), 1'b0, 1'b0, 1'b1);
      setAddr(pageBits'(3), 1'b0, 1'b0, 1'b0, 1'b1);
      runOp(opRead, 1'b0);
   endtask

   task automatic faultPriority();
      // Invalid with wrong mode and read only
      writePage(pageBits'(4), 1'b0, 1'b1, 1'b0);
      // Wrong mode and read only
      writePage(pageBits'(5), 1'b1, 1'b1, 1'b0);
      // Read only
      writePage(pageBits'(6), 1'b1, 1'b0, 1'b0);
      setAddr(pageBits'(4), 1'b0, 1'b0, 1'b0, 1'b1);
      runOp(opRead, 1'b0);
      runOp(opWrTest, 1'b0);
      setAddr(pageBits'(5), 1'b0, 1'b0, 1'b0, 1'b1);
      runOp(opWrTest, 1'b0);
      setAddr(pageBits'(6), 1'b0, 1'b0, 1'b0, 1'b1);
      runOp(opWrTest, 1'b0);
      // Plain write and read never check permission
      runOp(opWrite, 1'b0);
      runOp(opRead, 1'b0);
      // Unpaged references leave dispPf alone
      setAddr(pageBits'(4), 1'b0, 1'b1, 1'b0, 1'b1);
      runOp(opRead, 1'b0);
      setAddr(pageBits'(4), 1'b0, 1'b0, 1'b1, 1'b1);
      runOp(opRead, 1'b0);
      setAddr(pageBits'(4), 1'b0, 1'b0, 1'b0, 1'b0);
      runOp(opRead, 1'b0);
   endtask

   task automatic fetchInterrupts();
      writePage(pageBits'(7), 1'b1, 1'b0, 1'b1);
      setAddr(pageBits'(7), 1'b0, 1'b0, 1'b0, 1'b1);
      setIntr(1'b1, 1'b1);
      runOp(opFetch, 1'b0);
      setIntr(1'b1, 1'b0);
      runOp(opFetch, 1'b0);
      setIntr(1'b0, 1'b1);
      runOp(opFetch, 1'b0);
      // Levels outside the fetch window
      setIntr(1'b1, 1'b1);
      runOp(opRead, 1'b0);
      runOp(opWrTest, 1'b0);
      setIntr(1'b0, 1'b0);
   endtask

   task automatic intervalTimerRun();
      setAddr(pageBits'(2), 1'b0, 1'b0, 1'b0, 1'b0);
      resetDut();
      timerInterval();
      runOp(opFetch, 1'b1);
      // Count restarts at the taking edge
      timerInterval();
      setAddr(pageBits'(2), 1'b0, 1'b0, 1'b0, 1'b1);
      runOp(opFetch, 1'b1);
   endtask

   task automatic memClearAndStall();
      dispT        want;
      logic [31:0] heldCount;
      logic [31:0] heldTimer;
      runOp(opMemClr, 1'b0);
      setAddr(pageBits'(2), 1'b0, 1'b0, 1'b0, 1'b1);
      runOp(opRead, 1'b0);
      runOp(opMemClr, 1'b0);
      want = predictDisp(1'b0, 1'b1, 1'b0, 1'b0);
      // Open the window, then freeze everything
      @(posedge clk);
      microOp <= opRead;
      @(posedge clk);
      microOp <= opNop;
      clken   <= 1'b0;
      @(negedge clk);
      heldCount = 32'(i_pfUnit.i_intervalTimer.count);
      heldTimer = 32'(i_pfUnit.i_intervalTimer.timerIntr);
      repeat (stallCycles)
      begin
         @(negedge clk);
         checkVal("pageFail", 32'(pageFail), 32'(want != dispNone));
         checkVal("dispPf", 32'(dispPf), 32'(dispNone));
         checkVal("timer count", 32'(i_pfUnit.i_intervalTimer.count), heldCount);
         checkVal("timerIntr", 32'(i_pfUnit.i_intervalTimer.timerIntr), heldTimer);
      end
      @(posedge clk);
      clken <= 1'b1;
      @(negedge clk);
      checkVal("dispPf", 32'(dispPf), 32'(dispNone));
      @(negedge clk);
      checkVal("dispPf", 32'(dispPf), 32'(want));
      checkVal("pageFail", 32'(pageFail), 32'd0);
      expDisp = want;
   endtask

   //////////////////////////////////////////////////
   // Run control
   //////////////////////////////////////////////////

   initial
   begin
      #(watchdogCycles * 40);
      stopRun("Watchdog expired before the tests finished");
   end

   initial
   begin
      void'($urandom(50));
      clk           = 1'b0;
      rst           = 1'b1;
      clken         = 1'b1;
      microOp       = opNop;
      vmaUser       = 1'b0;
      vmaPhys       = 1'b0;
      vmaAcRef      = 1'b0;
      vmaPage       = '0;
      pageEnable    = 1'b0;
      piIntr        = 1'b0;
      nxmIntr       = 1'b0;
      ptWrReq       = 1'b0;
      ptWrPage      = '0;
      ptWrValid     = 1'b0;
      ptWrUser      = 1'b0;
      ptWrWriteable = 1'b0;
      resetDut();
      handshakeAndInvalid();
      faultPriority();
      fetchInterrupts();
      intervalTimerRun();
      memClearAndStall();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/pfUnit_chk.sv ====
/*
 * Bound assertions on the page-fail unit
 * Write handshake, dispatch load and dispatch code range
 */

`timescale 1ns/1ns
`default_nettype none

module pfUnit_chk
   import ksPkg::*;
(
   input wire       clk,
   input wire       rst,
   input wire       clken,
   input wire       ptWrReq,
   input wire       ptWrAck,
   input wire       pageFail,
   input wire dispT dispPf
);

   // Ack only ever answers a pending request
   ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
      $rose(ptWrAck) |-> $past(ptWrReq))
      else $error("ptWrAck rose without ptWrReq");

   // A failure seen on an enabled edge loads a real code
   failLoadsCode: assert property (@(posedge clk) disable iff (rst)
      (pageFail && clken) |=> (dispPf != dispNone))
      else $error("pageFail did not load a dispatch code");

   // Bad-data codes and spare values never appear
   codeInRange: assert property (@(posedge clk) disable iff (rst)
      dispPf inside {dispNone, dispIntr, dispNxm, dispWriteFail,
                     dispTimPagFail, dispInvalid, dispMismatch})
      else $error("dispPf holds an unknown code");

endmodule

bind pfUnit pfUnit_chk i_pfUnit_chk (
   .clk      (clk),
   .rst      (rst),
   .clken    (clken),
   .ptWrReq  (ptWrReq),
   .ptWrAck  (ptWrAck),
   .pageFail (pageFail),
   .dispPf   (dispPf)
);

`default_nettype wire

// ==== design/pfUnit.sv ====
/*
 * Page-fail unit top level
 * Decoder, page table, interval timer and dispatch block
 */

`timescale 1ns/1ns
`default_nettype none

module pfUnit
   import ksPkg::*;
(
   input  wire                clk,
   input  wire                rst,
   input  wire                clken,
   input  wire uOpT           microOp,
   // Virtual address bits, held by the environment
   input  wire                vmaUser,
   input  wire                vmaPhys,
   input  wire                vmaAcRef,
   input  wire [pageBits-1:0] vmaPage,
   input  wire                pageEnable,
   // Interrupt levels
   input  wire                piIntr,
   input  wire                nxmIntr,
   // Page table write port
   input  wire                ptWrReq,
   input  wire [pageBits-1:0] ptWrPage,
   input  wire                ptWrValid,
   input  wire                ptWrUser,
   input  wire                ptWrWriteable,
   output logic               ptWrAck,
   output logic               pageFail,
   output dispT               dispPf
);

   // Decode outputs
   logic memCycle;
   logic fetchCycle;
   logic memClr;
   logic wrTest;
   // Flags of the current page
   logic pageValid;
   logic pageUser;
   logic pageWriteable;
   // Timer loop
   logic timerIntr;
   logic intrTaken;

   memCycleDecode i_memCycleDecode (
      .microOp    (microOp),
      .memCycle   (memCycle),
      .fetchCycle (fetchCycle),
      .memClr     (memClr),
      .wrTest     (wrTest)
   );

   pageTable i_pageTable (
      .clk           (clk),
      .rst           (rst),
      .ptWrReq       (ptWrReq),
      .ptWrPage      (ptWrPage),
      .ptWrValid     (ptWrValid),
      .ptWrUser      (ptWrUser),
      .ptWrWriteable (ptWrWriteable),
      .ptWrAck       (ptWrAck),
      .vmaPage       (vmaPage),
      .pageValid     (pageValid),
      .pageUser      (pageUser),
      .pageWriteable (pageWriteable)
   );

   intervalTimer i_intervalTimer (
      .clk       (clk),
      .rst       (rst),
      .clken     (clken),
      .intrTaken (intrTaken),
      .timerIntr (timerIntr)
   );

   pageFailDispatch i_pageFailDispatch (
      .clk           (clk),
      .rst           (rst),
      .clken         (clken),
      .memCycle      (memCycle),
      .fetchCycle    (fetchCycle),
      .memClr        (memClr),
      .wrTest        (wrTest),
      .pageEnable    (pageEnable),
      .vmaUser       (vmaUser),
      .vmaPhys       (vmaPhys),
      .vmaAcRef      (vmaAcRef),
      .pageValid     (pageValid),
      .pageUser      (pageUser),
      .pageWriteable (pageWriteable),
      .timerIntr     (timerIntr),
      .piIntr        (piIntr),
      .nxmIntr       (nxmIntr),
      .pageFail      (pageFail),
      .dispPf        (dispPf),
      .intrTaken     (intrTaken)
   );

endmodule

`default_nettype wire

// ==== design/pageFailDispatch.sv ====
/*
 * Page-fail and interrupt dispatch
 * Page-fail and interrupt windows, fault qualification,
 * cause priority and the registered dispatch code
 */

`timescale 1ns/1ns
`default_nettype none

module pageFailDispatch
   import ksPkg::*;
(
   input  wire   clk,
   input  wire   rst,
   input  wire   clken,
   // From the decoder
   input  wire   memCycle,
   input  wire   fetchCycle,
   input  wire   memClr,
   input  wire   wrTest,
   // Paging control and address bits
   input  wire   pageEnable,
   input  wire   vmaUser,
   input  wire   vmaPhys,
   input  wire   vmaAcRef,
   // Page table flags for the current page
   input  wire   pageValid,
   input  wire   pageUser,
   input  wire   pageWriteable,
   // Interrupt levels
   input  wire   timerIntr,
   input  wire   piIntr,
   input  wire   nxmIntr,
   output logic  pageFail,
   output dispT  dispPf,
   output logic  intrTaken
);

   logic pfEn;
   logic wrTestQ;
   logic intrEn;
   logic pagedRef;
   logic pageInvalid;
   logic pageMismatch;
   logic pageWriteFail;
   dispT dispNext;

   //////////////////////////////////////////////////
   // Windows
   //////////////////////////////////////////////////

   // Page-fail window lasts one enabled cycle, never two in a row
   // Write-test qualifier captured with the opcode that opens it
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         pfEn    <= 1'b0;
         wrTestQ <= 1'b0;
         intrEn  <= 1'b0;
      end
      else if (clken)
      begin
         pfEn    <= ~pfEn & memCycle;
         wrTestQ <= ~pfEn & wrTest;
         // Interrupts only seen after an instruction fetch
         intrEn  <= fetchCycle;
      end
   end

   //////////////////////////////////////////////////
   // Fault qualification
   //////////////////////////////////////////////////

   // Physical and AC references bypass the pager
   assign pagedRef      = pageEnable & ~vmaPhys & ~vmaAcRef;
   assign pageInvalid   = pagedRef & ~pageValid;
   assign pageMismatch  = pagedRef & (vmaUser != pageUser);
   assign pageWriteFail = pagedRef & wrTestQ & ~pageWriteable;

   // Timer wins only when NXM and PI are both quiet
   assign intrTaken = intrEn & ~nxmIntr & ~piIntr & timerIntr;

   //////////////////////////////////////////////////
   // Cause priority
   //////////////////////////////////////////////////

   always_comb
   begin
      pageFail = 1'b1;
      dispNext = dispNone;
      if (intrEn & nxmIntr)
         dispNext = dispNxm;
      else if (intrEn & piIntr)
         dispNext = dispIntr;
      else if (intrTaken & pageInvalid)
         dispNext = dispTimPagFail;
      else if (intrTaken)
         dispNext = dispIntr;
      else if (pfEn & pageInvalid)
         dispNext = dispInvalid;
      else if (pfEn & pageMismatch)
         dispNext = dispMismatch;
      else if (pfEn & pageWriteFail)
         dispNext = dispWriteFail;
      else
         pageFail = 1'b0;
   end

   // Dispatch register, a new failure beats memory clear
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         dispPf <= dispNone;
      else if (clken)
      begin
         if (pageFail)
            dispPf <= dispNext;
         else if (memClr)
            dispPf <= dispNone;
      end
   end

endmodule

`default_nettype wire

// ==== design/intervalTimer.sv ====
/*
 * Interval timer
 * Counts enabled cycles, raises a pending timer interrupt
 */

`timescale 1ns/1ns
`default_nettype none

module intervalTimer
   import ksPkg::*;
(
   input  wire  clk,
   input  wire  rst,
   input  wire  clken,
   // Timer chosen as the dispatch cause
   input  wire  intrTaken,
   output logic timerIntr
);

   logic [timerBits-1:0] count;

   // Counter parks at zero while the interrupt is pending
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         count     <= '0;
         timerIntr <= 1'b0;
      end
      else if (clken)
      begin
         if (timerIntr)
         begin
            // Taking the interrupt restarts the interval
            if (intrTaken)
               timerIntr <= 1'b0;
         end
         else if (count == timerBits'(timerPeriod - 1))
         begin
            timerIntr <= 1'b1;
            count     <= '0;
         end
         else
            count <= count + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== design/memCycleDecode.sv ====
/*
 * Micro-operation decode
 * Memory cycle, fetch, memory clear and write-test indications
 */

`timescale 1ns/1ns
`default_nettype none

module memCycleDecode
   import ksPkg::*;
(
   input  wire uOpT microOp,
   output logic     memCycle,
   output logic     fetchCycle,
   output logic     memClr,
   output logic     wrTest
);

   // New opcodes only need an entry here
   always_comb
   begin
      memCycle   = 1'b0;
      fetchCycle = 1'b0;
      memClr     = 1'b0;
      wrTest     = 1'b0;
      case (microOp)
         opFetch:
            fetchCycle = 1'b1;
         opRead,
         opWrite:
            memCycle = 1'b1;
         opWrTest:
         begin
            // Memory cycle that also checks write permission
            memCycle = 1'b1;
            wrTest   = 1'b1;
         end
         opMemClr:
            memClr = 1'b1;
         // opNop and unused codes do nothing
         default:
            ;
      endcase
   end

endmodule

`default_nettype wire

// ==== pager/pageTable.sv ====
/*
 * Page flag store
 * Four-phase req/ack write port
 * Combinational lookup of the current virtual page
 */

`timescale 1ns/1ns
`default_nettype none

module pageTable
   import ksPkg::*;
(
   input  wire                clk,
   input  wire                rst,
   // Write port
   input  wire                ptWrReq,
   input  wire [pageBits-1:0] ptWrPage,
   input  wire                ptWrValid,
   input  wire                ptWrUser,
   input  wire                ptWrWriteable,
   output logic               ptWrAck,
   // Lookup port
   input  wire [pageBits-1:0] vmaPage,
   output logic               pageValid,
   output logic               pageUser,
   output logic               pageWriteable
);

   // One flag bit per page in each vector
   logic [pageCount-1:0] validBits;
   logic [pageCount-1:0] userBits;
   logic [pageCount-1:0] writeableBits;

   // Write once per request, on the edge that raises ack
   logic wrStrobe;

   assign wrStrobe = ptWrReq & ~ptWrAck;

   //////////////////////////////////////////////////
   // Handshake and valid bits
   //////////////////////////////////////////////////

   // Ack follows req by one edge, no clock enable here
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ptWrAck   <= 1'b0;
         validBits <= '0;
      end
      else
      begin
         ptWrAck <= ptWrReq;
         if (wrStrobe)
            validBits[ptWrPage] <= ptWrValid;
      end
   end

   // Mode and write permission
   always_ff @(posedge clk)
   begin
      if (wrStrobe)
      begin
         userBits[ptWrPage]      <= ptWrUser;
         writeableBits[ptWrPage] <= ptWrWriteable;
      end
   end

   // Zero-latency lookup
   assign pageValid     = validBits[vmaPage];
   assign pageUser      = userBits[vmaPage];
   assign pageWriteable = writeableBits[vmaPage];

endmodule

`default_nettype wire

// ==== common/ksPkg.sv ====
/*
 * Shared definitions for the page-fail front end
 * Micro-operation and dispatch code enums
 * Page table and interval timer sizing constants
 */

`default_nettype none

package ksPkg;

   //////////////////////////////////////////////////
   // Sizing
   //////////////////////////////////////////////////

   // Virtual page number width
   localparam int pageBits = 4;

   // Entries in the page table
   localparam int pageCount = 1 << pageBits;

   // Enabled cycles between timer interrupts
   localparam int timerPeriod = 64;

   // Interval counter width
   localparam int timerBits = $clog2(timerPeriod);

   //////////////////////////////////////////////////
   // Micro-operations
   //////////////////////////////////////////////////

   // Stand-in for the control store and dispatch ROM fields
   typedef enum logic [2:0] {
      opNop    = 3'd0,
      // Instruction fetch, opens the interrupt window
      opFetch  = 3'd1,
      opRead   = 3'd2,
      opWrite  = 3'd3,
      // Write-test cycle
      opWrTest = 3'd4,
      // Clears the dispatch register
      opMemClr = 3'd5
   } uOpT;

   //////////////////////////////////////////////////
   // Page-fail dispatch codes
   //////////////////////////////////////////////////

   // Codes 3 and 7 (bad data) never produced
   typedef enum logic [3:0] {
      dispNone       = 4'd0,
      dispIntr       = 4'd1,
      dispNxm        = 4'd5,
      dispWriteFail  = 4'd8,
      dispTimPagFail = 4'd9,
      dispInvalid    = 4'd10,
      dispMismatch   = 4'd11
   } dispT;

endpackage

`default_nettype wire
